/* ldq_ctrl.sv */
// --------------------------------------------------
// load queue control: entry array, per-entry FSMs,
// head/tail pointers and commit
// --------------------------------------------------

`timescale 1ns/1ps

`include "ldq_defs.svh"

module ldq_ctrl import ldq_pkg::*; (
    input  logic                            CLK,
    input  logic                            nRST,
    input  logic                            enq_valid,
    input  ldq_enq_t                        enq,
    input  logic                            info_ret_valid,
    input  ldq_info_ret_t                   info_ret,
    input  logic                            tlb_resp_valid,
    input  ldq_tlb_resp_t                   tlb_resp,
    input  logic                            dcache_resp_valid,
    input  ldq_dcache_resp_t                dcache_resp,
    input  logic                            commit_valid,
    input  ldq_grant_t                      second_try_grant,
    input  ldq_grant_t                      data_try_grant,
    output ldq_entry_t [`LDQ_ENTRIES-1:0]   entries,
    output logic [`LDQ_IDX_W-1:0]           head_idx,
    output logic [`LDQ_ENTRIES-1:0]         second_try_req,
    output logic [`LDQ_ENTRIES-1:0]         data_try_req,
    output logic                            enq_full
);

    localparam int IDX_W = `LDQ_IDX_W;

    // --------------------------------------------------
    // storage

    ldq_state_e                 state_q [`LDQ_ENTRIES];
    ldq_state_e                 state_d [`LDQ_ENTRIES];
    ldq_enq_t                   enq_q [`LDQ_ENTRIES];
    logic [`PA_WORD_W-1:0]      pa_word_q [`LDQ_ENTRIES];
    logic [3:0]                 byte_mask_q [`LDQ_ENTRIES];
    logic [31:0]                data_q [`LDQ_ENTRIES];

    logic [IDX_W-1:0]           tail_idx;
    logic                       enq_take;
    logic                       commit_take;

    // per-entry event strobes, qualified by state
    logic [`LDQ_ENTRIES-1:0]    info_sel, tlb_sel, dc_sel;
    logic [`LDQ_ENTRIES-1:0]    info_take, tlb_take, dc_take;

    assign enq_full    = (state_q[tail_idx] != ST_FREE);
    assign enq_take    = enq_valid & ~enq_full;
    assign commit_take = commit_valid & (state_q[head_idx] == ST_DONE);

    // --------------------------------------------------
    // event demux and next state

    always_comb begin
        info_sel = '0;
        tlb_sel  = '0;
        dc_sel   = '0;
        info_sel[info_ret.cq_index]  = info_ret_valid;
        tlb_sel[tlb_resp.cq_index]   = tlb_resp_valid;
        dc_sel[dcache_resp.cq_index] = dcache_resp_valid;

        for (int i = 0; i < `LDQ_ENTRIES; i++) begin
            info_take[i] = info_sel[i] & (state_q[i] == ST_WAIT_INFO);
            tlb_take[i]  = tlb_sel[i] & (state_q[i] == ST_WAIT_TLB);
            dc_take[i]   = dc_sel[i] & (state_q[i] == ST_WAIT_DCACHE);

            state_d[i] = state_q[i];
            if (enq_take && tail_idx == IDX_W'(i)) begin
                state_d[i] = ST_WAIT_INFO;
            end
            if (info_take[i]) begin
                if (!info_ret.dtlb_hit) begin
                    state_d[i] = ST_WAIT_TLB;
                end else if (!info_ret.dcache_hit) begin
                    state_d[i] = ST_WAIT_DCACHE;
                end else begin
                    state_d[i] = ST_DATA_TRY;
                end
            end
            if (tlb_take[i]) begin
                state_d[i] = ST_SECOND_TRY;
            end
            if (dc_take[i]) begin
                state_d[i] = ST_DATA_TRY;
            end
            // second try goes back through the pipeline for a fresh return
            if (second_try_grant.valid && second_try_grant.idx == IDX_W'(i)) begin
                state_d[i] = ST_WAIT_INFO;
            end
            if (data_try_grant.valid && data_try_grant.idx == IDX_W'(i)) begin
                state_d[i] = ST_DONE;
            end
            if (commit_take && head_idx == IDX_W'(i)) begin
                state_d[i] = ST_FREE;
            end
        end
    end

    // --------------------------------------------------
    // state and pointers

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            for (int i = 0; i < `LDQ_ENTRIES; i++) begin
                state_q[i] <= ST_FREE;
            end
            tail_idx <= '0;
            head_idx <= '0;
        end else begin
            for (int i = 0; i < `LDQ_ENTRIES; i++) begin
                state_q[i] <= state_d[i];
            end
            if (enq_take) begin
                tail_idx <= (tail_idx == IDX_W'(`LDQ_ENTRIES-1)) ? '0 : tail_idx + 1'b1;
            end
            if (commit_take) begin
                head_idx <= (head_idx == IDX_W'(`LDQ_ENTRIES-1)) ? '0 : head_idx + 1'b1;
            end
        end
    end

    // payload fields
    always_ff @(posedge CLK) begin
        if (enq_take) begin
            enq_q[tail_idx] <= enq;
        end
        for (int i = 0; i < `LDQ_ENTRIES; i++) begin
            if (info_take[i]) begin
                pa_word_q[i]   <= info_ret.pa_word;
                byte_mask_q[i] <= info_ret.byte_mask;
                data_q[i]      <= info_ret.data;
            end
            // miss response replaces the ppn, page offset stays
            if (tlb_take[i]) begin
                pa_word_q[i] <= {tlb_resp.ppn, pa_word_q[i][`PO_WORD_W-1:0]};
            end
            if (dc_take[i]) begin
                data_q[i] <= dcache_resp.data;
            end
        end
    end

    // --------------------------------------------------
    // entry view and request vectors

    always_comb begin
        for (int i = 0; i < `LDQ_ENTRIES; i++) begin
            entries[i].state     = state_q[i];
            entries[i].op        = enq_q[i].op;
            entries[i].dest_pr   = enq_q[i].dest_pr;
            entries[i].rob_index = enq_q[i].rob_index;
            entries[i].pa_word   = pa_word_q[i];
            entries[i].byte_mask = byte_mask_q[i];
            entries[i].data      = data_q[i];
            second_try_req[i]    = (state_q[i] == ST_SECOND_TRY);
            data_try_req[i]      = (state_q[i] == ST_DATA_TRY);
        end
    end

endmodule

/* ldq_data_try.sv */
// --------------------------------------------------
// data-try arbitration, output register and
// load data extraction
// --------------------------------------------------

`timescale 1ns/1ps

`include "ldq_defs.svh"

module ldq_data_try import ldq_pkg::*; (
    input  logic                            CLK,
    input  logic                            nRST,
    input  ldq_entry_t [`LDQ_ENTRIES-1:0]   entries,
    input  logic [`LDQ_IDX_W-1:0]           head_idx,
    input  logic [`LDQ_ENTRIES-1:0]         data_try_req,
    input  logic                            data_try_ack,
    output logic                            data_try_valid,
    output ldq_data_try_t                   data_try,
    output ldq_grant_t                      data_try_grant
);

    logic                   pick_any;
    logic [`LDQ_IDX_W-1:0]  pick_idx;
    logic [`LDQ_IDX_W-1:0]  idx_q;
    logic                   hold;
    ldq_entry_t             sel;
    logic [1:0]             byte_off;
    logic [31:0]            shifted;

    ldq_oldest_pick u_pick (
        .req      (data_try_req),
        .head_idx (head_idx),
        .any      (pick_any),
        .pick_idx (pick_idx)
    );

    assign hold = data_try_valid & ~data_try_ack;

    assign data_try_grant.valid = ~hold & pick_any;
    assign data_try_grant.idx   = pick_idx;

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            data_try_valid <= 1'b0;
            idx_q          <= '0;
        end else if (~hold) begin
            data_try_valid <= pick_any;
            idx_q          <= pick_idx;
        end
    end

    // --------------------------------------------------
    // extraction

    assign sel = entries[idx_q];

    always_comb begin
        // byte offset is the lowest enabled lane
        casez (sel.byte_mask)
            4'b???1: byte_off = 2'd0;
            4'b??10: byte_off = 2'd1;
            4'b?100: byte_off = 2'd2;
            4'b1000: byte_off = 2'd3;
            default: byte_off = 2'd0;
        endcase
        shifted = sel.data >> {byte_off, 3'b000};

        data_try.cq_index  = idx_q;
        data_try.dest_pr   = sel.dest_pr;
        data_try.rob_index = sel.rob_index;
        case (sel.op)
            LB:      data_try.data = {{24{shifted[7]}}, shifted[7:0]};
            LBU:     data_try.data = {24'b0, shifted[7:0]};
            LH:      data_try.data = {{16{shifted[15]}}, shifted[15:0]};
            LHU:     data_try.data = {16'b0, shifted[15:0]};
            default: data_try.data = sel.data;
        endcase
    end

endmodule

/* ldq_defs.svh */
// --------------------------------------------------
// load queue depth and field width macros
// --------------------------------------------------

`ifndef LDQ_DEFS_SVH
`define LDQ_DEFS_SVH

// queue geometry
`define LDQ_ENTRIES 8
`define LDQ_IDX_W 3

// core-side indices
`define ROB_IDX_W 6
`define PR_W 7

// physical address split, word granular
`define PPN_W 20
`define PO_WORD_W 10
`define PA_WORD_W (`PPN_W + `PO_WORD_W)

`endif

/* ldq_oldest_pick.sv */
// --------------------------------------------------
// oldest-first picker relative to the head index
// --------------------------------------------------

`timescale 1ns/1ps

`include "ldq_defs.svh"

module ldq_oldest_pick (
    input  logic [`LDQ_ENTRIES-1:0] req,
    input  logic [`LDQ_IDX_W-1:0]   head_idx,
    output logic                    any,
    output logic [`LDQ_IDX_W-1:0]   pick_idx
);

    localparam int IDX_W = `LDQ_IDX_W;

    logic [`LDQ_ENTRIES-1:0]    wrap_mask;
    logic [`LDQ_ENTRIES-1:0]    masked_req;
    logic [IDX_W-1:0]           masked_idx;
    logic [IDX_W-1:0]           unmasked_idx;

    // lowest set bit, index 0 when empty
    function automatic logic [IDX_W-1:0] lowest_set(input logic [`LDQ_ENTRIES-1:0] vec);
        logic [IDX_W-1:0] idx;
        idx = '0;
        for (int i = `LDQ_ENTRIES-1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = IDX_W'(i);
            end
        end
        return idx;
    endfunction

    always_comb begin
        // entries at or above head are older than those below it
        for (int i = 0; i < `LDQ_ENTRIES; i++) begin
            wrap_mask[i] = (IDX_W'(i) >= head_idx);
        end
        masked_req   = req & wrap_mask;
        masked_idx   = lowest_set(masked_req);
        unmasked_idx = lowest_set(req);
        any          = |req;
        pick_idx     = (|masked_req) ? masked_idx : unmasked_idx;
    end

endmodule

/* ldq_pkg.sv */
// --------------------------------------------------
// load queue types: opcode and entry-state enums,
// enqueue, return, entry and try structs
// --------------------------------------------------

`include "ldq_defs.svh"

package ldq_pkg;

    // funct3-style load encodings
    typedef enum logic [3:0] {
        LB  = 4'b0000,
        LH  = 4'b0001,
        LW  = 4'b0010,
        LBU = 4'b0100,
        LHU = 4'b0101
    } ldq_op_e;

    typedef enum logic [2:0] {
        ST_FREE,
        ST_WAIT_INFO,
        ST_WAIT_TLB,
        ST_WAIT_DCACHE,
        ST_SECOND_TRY,
        ST_DATA_TRY,
        ST_DONE
    } ldq_state_e;

    typedef struct packed {
        ldq_op_e                op;
        logic [`PR_W-1:0]       dest_pr;
        logic [`ROB_IDX_W-1:0]  rob_index;
    } ldq_enq_t;

    typedef struct packed {
        logic [`LDQ_IDX_W-1:0]  cq_index;
        logic                   dtlb_hit;
        logic                   dcache_hit;
        logic [`PA_WORD_W-1:0]  pa_word;
        logic [3:0]             byte_mask;
        logic [31:0]            data;
    } ldq_info_ret_t;

    typedef struct packed {
        logic [`LDQ_IDX_W-1:0]  cq_index;
        logic [`PPN_W-1:0]      ppn;
    } ldq_tlb_resp_t;

    typedef struct packed {
        logic [`LDQ_IDX_W-1:0]  cq_index;
        logic [31:0]            data;
    } ldq_dcache_resp_t;

    typedef struct packed {
        ldq_state_e             state;
        ldq_op_e                op;
        logic [`PR_W-1:0]       dest_pr;
        logic [`ROB_IDX_W-1:0]  rob_index;
        logic [`PA_WORD_W-1:0]  pa_word;
        logic [3:0]             byte_mask;
        logic [31:0]            data;
    } ldq_entry_t;

    typedef struct packed {
        logic [`LDQ_IDX_W-1:0]  cq_index;
        logic [`PPN_W-1:0]      ppn;
        logic [`PO_WORD_W-1:0]  po_word;
        logic [3:0]             byte_mask;
    } ldq_second_try_t;

    typedef struct packed {
        logic [`LDQ_IDX_W-1:0]  cq_index;
        logic [`PR_W-1:0]       dest_pr;
        logic [`ROB_IDX_W-1:0]  rob_index;
        logic [31:0]            data;
    } ldq_data_try_t;

    // taken pulse from a try stage back to control
    typedef struct packed {
        logic                   valid;
        logic [`LDQ_IDX_W-1:0]  idx;
    } ldq_grant_t;

endpackage

/* ldq_second_try.sv */
// --------------------------------------------------
// second-try arbitration and output register
// --------------------------------------------------

`timescale 1ns/1ps

`include "ldq_defs.svh"

module ldq_second_try import ldq_pkg::*; (
    input  logic                            CLK,
    input  logic                            nRST,
    input  ldq_entry_t [`LDQ_ENTRIES-1:0]   entries,
    input  logic [`LDQ_IDX_W-1:0]           head_idx,
    input  logic [`LDQ_ENTRIES-1:0]         second_try_req,
    input  logic                            second_try_ack,
    output logic                            second_try_valid,
    output ldq_second_try_t                 second_try,
    output ldq_grant_t                      second_try_grant
);

    logic                   pick_any;
    logic [`LDQ_IDX_W-1:0]  pick_idx;
    logic [`LDQ_IDX_W-1:0]  idx_q;
    logic                   hold;

    ldq_oldest_pick u_pick (
        .req      (second_try_req),
        .head_idx (head_idx),
        .any      (pick_any),
        .pick_idx (pick_idx)
    );

    // stalled while presented and not yet acked
    assign hold = second_try_valid & ~second_try_ack;

    assign second_try_grant.valid = ~hold & pick_any;
    assign second_try_grant.idx   = pick_idx;

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            second_try_valid <= 1'b0;
            idx_q            <= '0;
        end else if (~hold) begin
            second_try_valid <= pick_any;
            idx_q            <= pick_idx;
        end
    end

    // address split of the held entry
    always_comb begin
        second_try.cq_index  = idx_q;
        second_try.ppn       = entries[idx_q].pa_word[`PA_WORD_W-1 -: `PPN_W];
        second_try.po_word   = entries[idx_q].pa_word[`PO_WORD_W-1:0];
        second_try.byte_mask = entries[idx_q].byte_mask;
    end

endmodule

/* ldq_top.sv */
// --------------------------------------------------
// load queue top: control and both try stages
// --------------------------------------------------

`timescale 1ns/1ps

`include "ldq_defs.svh"

module ldq_top import ldq_pkg::*; (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                enq_valid,
    input  ldq_enq_t            enq,
    output logic                enq_full,
    input  logic                info_ret_valid,
    input  ldq_info_ret_t       info_ret,
    input  logic                tlb_resp_valid,
    input  ldq_tlb_resp_t       tlb_resp,
    input  logic                dcache_resp_valid,
    input  ldq_dcache_resp_t    dcache_resp,
    input  logic                commit_valid,
    output logic                second_try_valid,
    output ldq_second_try_t     second_try,
    input  logic                second_try_ack,
    output logic                data_try_valid,
    output ldq_data_try_t       data_try,
    input  logic                data_try_ack
);

    ldq_entry_t [`LDQ_ENTRIES-1:0]  entries;
    logic [`LDQ_IDX_W-1:0]          head_idx;
    logic [`LDQ_ENTRIES-1:0]        second_try_req;
    logic [`LDQ_ENTRIES-1:0]        data_try_req;
    ldq_grant_t                     second_try_grant;
    ldq_grant_t                     data_try_grant;

    ldq_ctrl u_ctrl (
        .CLK               (CLK),
        .nRST              (nRST),
        .enq_valid         (enq_valid),
        .enq               (enq),
        .info_ret_valid    (info_ret_valid),
        .info_ret          (info_ret),
        .tlb_resp_valid    (tlb_resp_valid),
        .tlb_resp          (tlb_resp),
        .dcache_resp_valid (dcache_resp_valid),
        .dcache_resp       (dcache_resp),
        .commit_valid      (commit_valid),
        .second_try_grant  (second_try_grant),
        .data_try_grant    (data_try_grant),
        .entries           (entries),
        .head_idx          (head_idx),
        .second_try_req    (second_try_req),
        .data_try_req      (data_try_req),
        .enq_full          (enq_full)
    );

    ldq_second_try u_second_try (
        .CLK              (CLK),
        .nRST             (nRST),
        .entries          (entries),
        .head_idx         (head_idx),
        .second_try_req   (second_try_req),
        .second_try_ack   (second_try_ack),
        .second_try_valid (second_try_valid),
        .second_try       (second_try),
        .second_try_grant (second_try_grant)
    );

    ldq_data_try u_data_try (
        .CLK            (CLK),
        .nRST           (nRST),
        .entries        (entries),
        .head_idx       (head_idx),
        .data_try_req   (data_try_req),
        .data_try_ack   (data_try_ack),
        .data_try_valid (data_try_valid),
        .data_try       (data_try),
        .data_try_grant (data_try_grant)
    );

endmodule

/* run.sh */
#!/bin/sh
# build and run the load queue testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -f tb.f --top-module tb_ldq -o Vtb_ldq > sim.log 2>&1 \
    && ./obj_dir/Vtb_ldq >> sim.log 2>&1
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "simulation did not pass"; exit 1; }
exit 0

/* tb.f */
+incdir+.
ldq_pkg.sv
ldq_oldest_pick.sv
ldq_ctrl.sv
ldq_second_try.sv
ldq_data_try.sv
ldq_top.sv
tb_ldq_assert.sv
tb_ldq.sv

/* tb_ldq.sv */
// --------------------------------------------------
// load queue testbench with clock, stimulus,
// reference function, compare process and check task
// --------------------------------------------------

`timescale 1ns/1ps

`include "ldq_defs.svh"

module tb_ldq import ldq_pkg::*; ();

    logic               CLK;
    logic               nRST;
    logic               enq_valid;
    ldq_enq_t           enq;
    logic               enq_full;
    logic               info_ret_valid;
    ldq_info_ret_t      info_ret;
    logic               tlb_resp_valid;
    ldq_tlb_resp_t      tlb_resp;
    logic               dcache_resp_valid;
    ldq_dcache_resp_t   dcache_resp;
    logic               commit_valid;
    logic               second_try_valid;
    ldq_second_try_t    second_try;
    logic               second_try_ack;
    logic               data_try_valid;
    ldq_data_try_t      data_try;
    logic               data_try_ack;

    // expected contents per slot
    ldq_op_e                exp_op [`LDQ_ENTRIES];
    logic [`PR_W-1:0]       exp_pr [`LDQ_ENTRIES];
    logic [`ROB_IDX_W-1:0]  exp_rob [`LDQ_ENTRIES];
    logic [31:0]            exp_data [`LDQ_ENTRIES];
    int                     enq_cnt [`LDQ_ENTRIES];
    int                     acc_cnt [`LDQ_ENTRIES];
    int                     order_q [$];
    int                     tail_cnt;
    logic [31:0]            seed;

    ldq_top uut (.*);

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // --------------------------------------------------
    // helpers

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = seed;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        seed = x;
        return x;
    endfunction

    // byte or halfword from the lowest enabled lane and extended
    function automatic logic [31:0] ref_load_data(input ldq_op_e op, input logic [3:0] mask,
                                                  input logic [31:0] word);
        int          off;
        logic [31:0] v;
        logic [31:0] res;
        off = 0;
        if (mask[0]) off = 0;
        else if (mask[1]) off = 1;
        else if (mask[2]) off = 2;
        else if (mask[3]) off = 3;
        v = word >> (8 * off);
        case (op)
            LB:      res = {{24{v[7]}}, v[7:0]};
            LBU:     res = {24'h0, v[7:0]};
            LH:      res = {{16{v[15]}}, v[15:0]};
            LHU:     res = {16'h0, v[15:0]};
            default: res = word;
        endcase
        return res;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic fail(input string what);
        $display("Failure at %0t ns: %s", $time, what);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic enq_random(output int slot);
        logic [31:0] r;
        ldq_op_e     op;
        r = next_rand();
        case (r % 5)
            0:       op = LB;
            1:       op = LH;
            2:       op = LW;
            3:       op = LBU;
            default: op = LHU;
        endcase
        slot = tail_cnt % `LDQ_ENTRIES;
        exp_op[slot]  = op;
        exp_pr[slot]  = r[14:8];
        exp_rob[slot] = r[21:16];
        @(posedge CLK);
        check("enq_full", enq_full, 0);
        enq_valid <= 1'b1;
        enq       <= '{op: op, dest_pr: r[14:8], rob_index: r[21:16]};
        enq_cnt[slot] = enq_cnt[slot] + 1;
        @(posedge CLK);
        enq_valid <= 1'b0;
        tail_cnt = tail_cnt + 1;
    endtask

    task automatic return_info(input int slot, input logic tlb_hit, input logic dc_hit,
                               input logic [`PA_WORD_W-1:0] pa, input logic [3:0] mask,
                               input logic [31:0] data);
        @(posedge CLK);
        info_ret_valid <= 1'b1;
        info_ret <= '{cq_index: slot[`LDQ_IDX_W-1:0], dtlb_hit: tlb_hit, dcache_hit: dc_hit,
                      pa_word: pa, byte_mask: mask, data: data};
        @(posedge CLK);
        info_ret_valid <= 1'b0;
    endtask

    function automatic logic [3:0] rand_mask();
        logic [31:0] r;
        r = next_rand();
        return (r[3:0] == 4'h0) ? 4'h1 : r[3:0];
    endfunction

    task automatic hit_return(input int slot);
        logic [31:0] d;
        logic [31:0] pa;
        logic [3:0]  m;
        d  = next_rand();
        pa = next_rand();
        m  = rand_mask();
        exp_data[slot] = ref_load_data(exp_op[slot], m, d);
        return_info(slot, 1'b1, 1'b1, pa[`PA_WORD_W-1:0], m, d);
    endtask

    task automatic wait_data(input int slot);
        int n;
        n = 0;
        while (acc_cnt[slot] < enq_cnt[slot]) begin
            @(posedge CLK);
            n++;
            if (n > 200) fail($sformatf("no data try for slot %0d", slot));
        end
    endtask

    task automatic commit_head();
        @(posedge CLK);
        commit_valid <= 1'b1;
        @(posedge CLK);
        commit_valid <= 1'b0;
    endtask

    // --------------------------------------------------
    // compare process

    always @(posedge CLK) begin
        int idx;
        if (nRST && data_try_valid && data_try_ack) begin
            idx = int'(data_try.cq_index);
            if (acc_cnt[idx] >= enq_cnt[idx]) fail("data try for a slot with no load");
            check("data_try.rob_index", data_try.rob_index, exp_rob[idx]);
            check("data_try.dest_pr", data_try.dest_pr, exp_pr[idx]);
            check("data_try.data", data_try.data, exp_data[idx]);
            acc_cnt[idx] = acc_cnt[idx] + 1;
            order_q.push_back(idx);
        end
    end

    // --------------------------------------------------
    // stimulus

    initial begin
        int              s;
        int              n;
        int              base;
        int              slots [4];
        logic [31:0]     r;
        logic [31:0]     d;
        logic [3:0]      m;
        ldq_data_try_t   held;

        seed     = 32'h91fb;
        tail_cnt = 0;
        for (int i = 0; i < `LDQ_ENTRIES; i++) begin
            enq_cnt[i]  = 0;
            acc_cnt[i]  = 0;
            exp_data[i] = '0;
        end
        nRST              <= 1'b0;
        enq_valid         <= 1'b0;
        enq               <= '0;
        info_ret_valid    <= 1'b0;
        info_ret          <= '0;
        tlb_resp_valid    <= 1'b0;
        tlb_resp          <= '0;
        dcache_resp_valid <= 1'b0;
        dcache_resp       <= '0;
        commit_valid      <= 1'b0;
        second_try_ack    <= 1'b1;
        data_try_ack      <= 1'b1;
        repeat (2) @(posedge CLK);
        nRST <= 1'b1;

        // idle after reset
        @(posedge CLK);
        check("second_try_valid", second_try_valid, 0);
        check("data_try_valid", data_try_valid, 0);
        check("enq_full", enq_full, 0);

        // hit path on slots 0..2
        for (int k = 0; k < 3; k++) begin
            enq_random(s);
            hit_return(s);
            wait_data(s);
        end
        repeat (3) commit_head();

        // tlb miss on slot 3
        enq_random(s);
        r = next_rand();
        m = rand_mask();
        return_info(s, 1'b0, 1'b1, r[`PA_WORD_W-1:0], m, next_rand());
        d = next_rand();
        @(posedge CLK);
        second_try_ack <= 1'b0;
        tlb_resp_valid <= 1'b1;
        tlb_resp       <= '{cq_index: s[`LDQ_IDX_W-1:0], ppn: d[`PPN_W-1:0]};
        @(posedge CLK);
        tlb_resp_valid <= 1'b0;
        n = 0;
        @(posedge CLK);
        while (!second_try_valid) begin
            n++;
            if (n > 100) fail("no second try after tlb response");
            @(posedge CLK);
        end
        check("second_try.cq_index", second_try.cq_index, s);
        check("second_try.ppn", second_try.ppn, d[`PPN_W-1:0]);
        check("second_try.po_word", second_try.po_word, r[`PO_WORD_W-1:0]);
        check("second_try.byte_mask", second_try.byte_mask, m);
        // second try stays presented until acked
        repeat (3) begin
            @(posedge CLK);
            check("second_try_valid", second_try_valid, 1);
            check("second_try.cq_index", second_try.cq_index, s);
        end
        second_try_ack <= 1'b1;
        hit_return(s);
        wait_data(s);
        commit_head();

        // cache miss on slot 4
        enq_random(s);
        m = rand_mask();
        r = next_rand();
        return_info(s, 1'b1, 1'b0, r[`PA_WORD_W-1:0], m, next_rand());
        d = next_rand();
        exp_data[s] = ref_load_data(exp_op[s], m, d);
        @(posedge CLK);
        dcache_resp_valid <= 1'b1;
        dcache_resp       <= '{cq_index: s[`LDQ_IDX_W-1:0], data: d};
        @(posedge CLK);
        dcache_resp_valid <= 1'b0;
        wait_data(s);
        commit_head();

        // back-pressure on slots 5 to 0 across the wrap
        @(posedge CLK);
        data_try_ack <= 1'b0;
        for (int k = 0; k < 4; k++) begin
            enq_random(slots[k]);
        end
        hit_return(slots[0]);
        hit_return(slots[3]);
        hit_return(slots[2]);
        hit_return(slots[1]);
        n = 0;
        while (!data_try_valid) begin
            n++;
            if (n > 100) fail("no data try while ack held low");
            @(posedge CLK);
        end
        held = data_try;
        check("data_try.cq_index", data_try.cq_index, slots[0]);
        repeat (6) begin
            @(posedge CLK);
            check("data_try_valid", data_try_valid, 1);
            check("data_try", data_try, held);
        end
        base = order_q.size();
        data_try_ack <= 1'b1;
        for (int k = 0; k < 4; k++) begin
            wait_data(slots[k]);
        end
        for (int k = 0; k < 4; k++) begin
            check("data try order", order_q[base + k], slots[k]);
        end
        repeat (4) commit_head();

        // fill all slots and try a ninth enqueue
        for (int k = 0; k < `LDQ_ENTRIES; k++) begin
            enq_random(s);
        end
        @(posedge CLK);
        check("enq_full", enq_full, 1);
        r = next_rand();
        enq_valid <= 1'b1;
        enq       <= '{op: LW, dest_pr: r[6:0], rob_index: r[13:8]};
        @(posedge CLK);
        enq_valid <= 1'b0;
        for (int k = 0; k < `LDQ_ENTRIES; k++) begin
            s = (tail_cnt - `LDQ_ENTRIES + k) % `LDQ_ENTRIES;
            hit_return(s);
        end
        for (int k = 0; k < `LDQ_ENTRIES; k++) begin
            wait_data(k);
        end
        commit_head();
        @(posedge CLK);
        check("enq_full", enq_full, 0);
        repeat (`LDQ_ENTRIES - 1) commit_head();

        // slot freed by the first commit is reused
        enq_random(s);
        hit_return(s);
        wait_data(s);
        commit_head();

        repeat (2) @(posedge CLK);
        $display("TEST PASSED");
        $finish;
    end

endmodule

/* tb_ldq_assert.sv */
// --------------------------------------------------
// bound assertions on the load queue top ports
// --------------------------------------------------

`timescale 1ns/1ps

`include "ldq_defs.svh"

module tb_ldq_assert import ldq_pkg::*; (
    input logic             CLK,
    input logic             nRST,
    input logic             commit_valid,
    input logic             enq_full,
    input logic             second_try_valid,
    input ldq_second_try_t  second_try,
    input logic             second_try_ack,
    input logic             data_try_valid,
    input ldq_data_try_t    data_try,
    input logic             data_try_ack
);

    // stalled outputs hold their payload
    second_try_hold: assert property (@(posedge CLK) disable iff (!nRST)
        second_try_valid && !second_try_ack |=> second_try_valid && $stable(second_try))
        else $error("second try changed while stalled");

    data_try_hold: assert property (@(posedge CLK) disable iff (!nRST)
        data_try_valid && !data_try_ack |=> data_try_valid && $stable(data_try))
        else $error("data try changed while stalled");

    quiet_in_reset: assert property (@(posedge CLK)
        !nRST |-> !second_try_valid && !data_try_valid)
        else $error("try valid during reset");

    // commit of a done head frees a slot
    full_clears: assert property (@(posedge CLK) disable iff (!nRST)
        commit_valid && enq_full |=> !enq_full)
        else $error("queue still full after commit");

endmodule

bind ldq_top tb_ldq_assert u_assert (.*);
